// File: design/mem_pkg.sv
// memory subsystem shared widths, opcode enums, cache commands and access size codes
package mem_pkg;

    localparam int XLEN  = 64;
    localparam int REG_W = 5;

    typedef logic [XLEN-1:0]  bus64_t;
    typedef logic [XLEN-1:0]  addr_t;
    typedef logic [REG_W-1:0] reg_t;

    // instruction class seen by the load/store unit
    typedef enum logic [1:0] {
        MEM_LOAD  = 2'b00,
        MEM_STORE = 2'b01,
        MEM_AMO   = 2'b10
    } mem_op_t;

    typedef enum logic [3:0] {
        AMO_LR   = 4'd0,
        AMO_SC   = 4'd1,
        AMO_SWAP = 4'd2,
        AMO_ADD  = 4'd3,
        AMO_XOR  = 4'd4,
        AMO_AND  = 4'd5,
        AMO_OR   = 4'd6,
        AMO_MIN  = 4'd7,
        AMO_MAX  = 4'd8,
        AMO_MINU = 4'd9,
        AMO_MAXU = 4'd10
    } amo_op_t;

    // ------------------------------
    // data cache command codes
    // ------------------------------
    typedef enum logic [4:0] {
        DC_LOAD  = 5'b00000,
        DC_STORE = 5'b00001,
        DC_SWAP  = 5'b00100,
        DC_LR    = 5'b00110,
        DC_SC    = 5'b00111,
        DC_ADD   = 5'b01000,
        DC_XOR   = 5'b01001,
        DC_OR    = 5'b01010,
        DC_AND   = 5'b01011,
        DC_MIN   = 5'b01100,
        DC_MAX   = 5'b01101,
        DC_MINU  = 5'b01110,
        DC_MAXU  = 5'b01111
    } dcache_cmd_t;

    // funct3 size codes, bit 2 set means zero extension
    localparam logic [2:0] SZ_B  = 3'b000;
    localparam logic [2:0] SZ_H  = 3'b001;
    localparam logic [2:0] SZ_W  = 3'b010;
    localparam logic [2:0] SZ_D  = 3'b011;
    localparam logic [2:0] SZ_BU = 3'b100;
    localparam logic [2:0] SZ_HU = 3'b101;
    localparam logic [2:0] SZ_WU = 3'b110;

endpackage

// File: design/amo_alu.sv
// atomic memory operation unit, computes the value written back by an AMO
module amo_alu import mem_pkg::*; (
    input  amo_op_t amo_op_i,
    input  logic    word_i,      // 32-bit operation
    input  bus64_t  mem_data_i,  // old memory value, low aligned
    input  bus64_t  src_data_i,  // rs2
    output bus64_t  result_o
);

    bus64_t op_a;
    bus64_t op_b;
    bus64_t raw;
    logic   lt_s;
    logic   lt_u;

    // word operands are sign extended so one 64-bit compare serves both widths
    assign op_a = word_i ? {{32{mem_data_i[31]}}, mem_data_i[31:0]} : mem_data_i;
    assign op_b = word_i ? {{32{src_data_i[31]}}, src_data_i[31:0]} : src_data_i;

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;  // ordering kept after sign extension

    always_comb begin
        case (amo_op_i)
            AMO_SWAP: raw = op_b;
            AMO_ADD:  raw = op_a + op_b;
            AMO_XOR:  raw = op_a ^ op_b;
            AMO_AND:  raw = op_a & op_b;
            AMO_OR:   raw = op_a | op_b;
            AMO_MIN:  raw = lt_s ? op_a : op_b;
            AMO_MAX:  raw = lt_s ? op_b : op_a;
            AMO_MINU: raw = lt_u ? op_a : op_b;
            AMO_MAXU: raw = lt_u ? op_b : op_a;
            default:  raw = op_b;   // lr/sc pass the source through
        endcase
    end

    assign result_o = word_i ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

// File: design/data_scratchpad.sv
// fixed-latency data scratchpad standing in for the data cache, with lr/sc and an io register
module data_scratchpad import mem_pkg::*; #(
    parameter int    MEM_WORDS    = 256,
    parameter int    RESP_LATENCY = 2,
    parameter addr_t IO_BASE      = 64'h1000,
    parameter addr_t IO_LIMIT     = 64'h100F
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        req_valid_i,
    input  dcache_cmd_t req_cmd_i,
    input  addr_t       req_addr_i,
    input  logic [2:0]  op_type_i,
    input  bus64_t      req_data_i,
    input  logic [7:0]  req_tag_i,
    input  logic        req_invalidate_lr_i,
    input  logic        req_kill_i,
    output logic        req_ready_o,
    output logic        resp_valid_o,
    output bus64_t      resp_data_o,
    output logic        xcpt_ma_ld_o,
    output logic        xcpt_ma_st_o,
    output logic        xcpt_pf_ld_o,
    output logic        xcpt_pf_st_o,
    output bus64_t      io_data_o
);

    localparam int    IDX_W     = $clog2(MEM_WORDS);
    localparam addr_t MEM_BYTES = addr_t'(MEM_WORDS) << 3;

    bus64_t                ram_q [MEM_WORDS];
    bus64_t                io_q;
    logic                  ready_q;
    logic [RESP_LATENCY-1:0] resp_vld_q;
    bus64_t                resp_data_q [RESP_LATENCY];
    logic                  resv_valid_q;
    logic [XLEN-4:0]       resv_dw_q;

    logic [IDX_W-1:0] idx;
    logic [5:0]       sh_amt;
    logic             in_io;
    logic             in_mem;
    logic             is_load;
    logic             is_rmw;
    logic             misaligned;
    logic             xcpt;
    logic             accept_ok;
    logic             io_store;
    logic             sc_ok;
    logic             wr_en;
    logic [7:0]       byte_en;
    logic [7:0]       be_sh;
    bus64_t           bit_mask;
    bus64_t           old_word;
    bus64_t           old_sh;
    bus64_t           amo_res;
    bus64_t           wval;
    bus64_t           new_word;
    bus64_t           load_ext;
    bus64_t           resp_val;
    amo_op_t          amo_op;

    // ------------------------------
    // decode and exceptions
    // ------------------------------
    assign idx     = req_addr_i[IDX_W+2:3];
    assign sh_amt  = {req_addr_i[2:0], 3'b000};
    assign in_io   = (req_addr_i >= IO_BASE) && (req_addr_i <= IO_LIMIT);
    assign in_mem  = req_addr_i < MEM_BYTES;
    assign is_load = (req_cmd_i == DC_LOAD) || (req_cmd_i == DC_LR);

    always_comb begin
        case (op_type_i[1:0])
            2'b00: begin
                byte_en    = 8'h01;
                misaligned = 1'b0;
            end
            2'b01: begin
                byte_en    = 8'h03;
                misaligned = req_addr_i[0];
            end
            2'b10: begin
                byte_en    = 8'h0F;
                misaligned = |req_addr_i[1:0];
            end
            default: begin
                byte_en    = 8'hFF;
                misaligned = |req_addr_i[2:0];
            end
        endcase
    end

    // misaligned takes priority over out of range
    assign xcpt_ma_ld_o = req_valid_i & is_load & misaligned;
    assign xcpt_ma_st_o = req_valid_i & ~is_load & misaligned;
    assign xcpt_pf_ld_o = req_valid_i & is_load & ~misaligned & ~in_mem & ~in_io;
    assign xcpt_pf_st_o = req_valid_i & ~is_load & ~misaligned & ~in_mem & ~in_io;
    assign xcpt = xcpt_ma_ld_o | xcpt_ma_st_o | xcpt_pf_ld_o | xcpt_pf_st_o;

    assign req_ready_o = ready_q;
    assign accept_ok   = req_valid_i & ready_q & ~xcpt & ~req_kill_i;
    assign io_store    = in_io & (req_cmd_i == DC_STORE);

    // ------------------------------
    // read-modify-write datapath
    // ------------------------------
    always_comb begin
        is_rmw = 1'b1;
        case (req_cmd_i)
            DC_SWAP: amo_op = AMO_SWAP;
            DC_ADD:  amo_op = AMO_ADD;
            DC_XOR:  amo_op = AMO_XOR;
            DC_AND:  amo_op = AMO_AND;
            DC_OR:   amo_op = AMO_OR;
            DC_MIN:  amo_op = AMO_MIN;
            DC_MAX:  amo_op = AMO_MAX;
            DC_MINU: amo_op = AMO_MINU;
            DC_MAXU: amo_op = AMO_MAXU;
            default: begin
                amo_op = AMO_SWAP;
                is_rmw = 1'b0;
            end
        endcase
    end

    assign old_word = in_io ? io_q : ram_q[idx];
    assign old_sh   = old_word >> sh_amt;

    amo_alu i_amo_alu (
        .amo_op_i   (amo_op),
        .word_i     (op_type_i[1:0] == 2'b10),
        .mem_data_i (old_sh),
        .src_data_i (req_data_i),
        .result_o   (amo_res)
    );

    assign be_sh = byte_en << req_addr_i[2:0];

    always_comb begin
        for (int b = 0; b < 8; b++) begin
            bit_mask[8*b +: 8] = {8{be_sh[b]}};
        end
    end

    assign wval     = (is_rmw ? amo_res : req_data_i) << sh_amt;
    assign new_word = (old_word & ~bit_mask) | (wval & bit_mask);

    assign sc_ok = resv_valid_q && (resv_dw_q == req_addr_i[XLEN-1:3]);
    assign wr_en = accept_ok & ((req_cmd_i == DC_STORE) | is_rmw | ((req_cmd_i == DC_SC) & sc_ok));

    // load extension per size code
    always_comb begin
        case (op_type_i)
            SZ_B:    load_ext = {{56{old_sh[7]}}, old_sh[7:0]};
            SZ_H:    load_ext = {{48{old_sh[15]}}, old_sh[15:0]};
            SZ_W:    load_ext = {{32{old_sh[31]}}, old_sh[31:0]};
            SZ_BU:   load_ext = {56'b0, old_sh[7:0]};
            SZ_HU:   load_ext = {48'b0, old_sh[15:0]};
            SZ_WU:   load_ext = {32'b0, old_sh[31:0]};
            default: load_ext = old_sh;
        endcase
    end

    assign resp_val = (req_cmd_i == DC_SC) ? {63'b0, ~sc_ok} : load_ext;

    // ------------------------------
    // state
    // ------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                ram_q[i] <= '0;
            end
        end else if (wr_en && !in_io) begin
            ram_q[idx] <= new_word;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ready_q      <= 1'b1;
            io_q         <= '0;
            resv_valid_q <= 1'b0;
            resp_vld_q   <= '0;
        end else begin
            ready_q <= ~wr_en;  // one idle cycle after every write
            if (wr_en && in_io) begin
                io_q <= new_word;
            end
            if (req_invalidate_lr_i) begin
                resv_valid_q <= 1'b0;
            end else if (accept_ok && req_cmd_i == DC_LR) begin
                resv_valid_q <= 1'b1;
            end else if (accept_ok && (req_cmd_i == DC_SC || (wr_en && sc_ok))) begin
                resv_valid_q <= 1'b0;
            end
            resp_vld_q[0] <= accept_ok & ~io_store;
            for (int i = 1; i < RESP_LATENCY; i++) begin
                resp_vld_q[i] <= resp_vld_q[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        resp_data_q[0] <= resp_val;
        for (int i = 1; i < RESP_LATENCY; i++) begin
            resp_data_q[i] <= resp_data_q[i-1];
        end
        if (accept_ok && req_cmd_i == DC_LR) begin
            resv_dw_q <= req_addr_i[XLEN-1:3];
        end
    end

    assign resp_valid_o = resp_vld_q[RESP_LATENCY-1];
    assign resp_data_o  = resp_data_q[RESP_LATENCY-1];
    assign io_data_o    = io_q;

endmodule

// File: design/mem_unit.sv
// load/store unit, forms the address, encodes the cache command and sequences one request
module mem_unit import mem_pkg::*; #(
    parameter addr_t IO_BASE  = 64'h1000,
    parameter addr_t IO_LIMIT = 64'h100F
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        valid_i,
    input  logic        kill_i,
    input  logic        csr_eret_i,
    input  bus64_t      data_rs1_i,
    input  bus64_t      data_rs2_i,
    input  bus64_t      imm_i,
    input  mem_op_t     mem_op_i,
    input  amo_op_t     amo_op_i,
    input  logic [2:0]  funct3_i,
    input  reg_t        rd_i,
    input  logic        dmem_req_ready_i,
    input  logic        dmem_resp_valid_i,
    input  bus64_t      dmem_resp_data_i,
    input  logic        dmem_xcpt_ma_ld_i,
    input  logic        dmem_xcpt_ma_st_i,
    input  logic        dmem_xcpt_pf_ld_i,
    input  logic        dmem_xcpt_pf_st_i,
    output logic        dmem_req_valid_o,
    output dcache_cmd_t dmem_req_cmd_o,
    output addr_t       dmem_req_addr_o,
    output logic [2:0]  dmem_op_type_o,
    output bus64_t      dmem_req_data_o,
    output logic [7:0]  dmem_req_tag_o,
    output logic        dmem_req_invalidate_lr_o,
    output logic        dmem_req_kill_o,
    output logic        ready_o,
    output bus64_t      data_o,
    output logic        lock_o
);

    typedef enum logic [1:0] {
        ResetState   = 2'b00,
        Idle         = 2'b01,
        MakeRequest  = 2'b10,
        WaitResponse = 2'b11
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   mem_xcpt;
    logic   xcpt_q;     // acceptance raised an exception
    logic   io_store;
    logic   in_flight;

    // ------------------------------
    // control
    // ------------------------------
    assign mem_xcpt = dmem_xcpt_ma_ld_i | dmem_xcpt_ma_st_i | dmem_xcpt_pf_ld_i | dmem_xcpt_pf_st_i;
    assign io_store = (dmem_req_addr_o >= IO_BASE) && (dmem_req_addr_o <= IO_LIMIT)
                      && (mem_op_i == MEM_STORE);   // io stores never answer

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ResetState;
            xcpt_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            xcpt_q  <= dmem_req_valid_o & mem_xcpt;
        end
    end

    always_comb begin
        state_d          = state_q;
        dmem_req_valid_o = 1'b0;
        lock_o           = 1'b0;
        case (state_q)
            ResetState: state_d = Idle;
            Idle: begin
                lock_o           = valid_i & ~kill_i;
                dmem_req_valid_o = valid_i & ~kill_i & dmem_req_ready_i;
                if (dmem_req_valid_o) begin
                    state_d = MakeRequest;
                end
            end
            MakeRequest: begin
                if (dmem_resp_valid_i || xcpt_q || kill_i || io_store) begin
                    state_d = Idle;
                end else begin
                    lock_o  = 1'b1;
                    state_d = WaitResponse;
                end
            end
            WaitResponse: begin
                if (dmem_resp_valid_i || kill_i || io_store) begin
                    state_d = Idle;
                end else begin
                    lock_o = 1'b1;
                end
            end
            default: state_d = ResetState;
        endcase
    end

    // ------------------------------
    // request fields
    // ------------------------------
    always_comb begin
        case (mem_op_i)
            MEM_STORE: dmem_req_cmd_o = DC_STORE;
            MEM_AMO: begin
                case (amo_op_i)
                    AMO_LR:   dmem_req_cmd_o = DC_LR;
                    AMO_SC:   dmem_req_cmd_o = DC_SC;
                    AMO_SWAP: dmem_req_cmd_o = DC_SWAP;
                    AMO_ADD:  dmem_req_cmd_o = DC_ADD;
                    AMO_XOR:  dmem_req_cmd_o = DC_XOR;
                    AMO_AND:  dmem_req_cmd_o = DC_AND;
                    AMO_OR:   dmem_req_cmd_o = DC_OR;
                    AMO_MIN:  dmem_req_cmd_o = DC_MIN;
                    AMO_MAX:  dmem_req_cmd_o = DC_MAX;
                    AMO_MINU: dmem_req_cmd_o = DC_MINU;
                    AMO_MAXU: dmem_req_cmd_o = DC_MAXU;
                    default:  dmem_req_cmd_o = DC_LOAD;
                endcase
            end
            default: dmem_req_cmd_o = DC_LOAD;
        endcase
    end

    // atomics use rs1 with no offset
    assign dmem_req_addr_o          = (mem_op_i == MEM_AMO) ? data_rs1_i : data_rs1_i + imm_i;
    assign dmem_op_type_o           = funct3_i;
    assign dmem_req_data_o          = data_rs2_i;
    assign dmem_req_tag_o           = {2'b00, rd_i, 1'b0};  // bit 0 low, integer rd
    assign dmem_req_invalidate_lr_o = csr_eret_i;
    assign dmem_req_kill_o          = mem_xcpt | kill_i;

    // ------------------------------
    // writeback
    // ------------------------------
    assign in_flight = (state_q == MakeRequest) || (state_q == WaitResponse);
    assign ready_o   = dmem_resp_valid_i & in_flight & (mem_op_i != MEM_STORE);
    assign data_o    = dmem_resp_data_i;

endmodule

// File: design/mem_subsystem_top.sv
// memory subsystem top, load/store unit in front of the data scratchpad
module mem_subsystem_top import mem_pkg::*; #(
    parameter addr_t IO_BASE      = 64'h1000,
    parameter addr_t IO_LIMIT     = 64'h100F,
    parameter int    MEM_WORDS    = 256,
    parameter int    RESP_LATENCY = 2
) (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  logic       valid_i,
    input  logic       kill_i,
    input  logic       csr_eret_i,
    input  bus64_t     data_rs1_i,
    input  bus64_t     data_rs2_i,
    input  mem_op_t    mem_op_i,
    input  amo_op_t    amo_op_i,
    input  logic [2:0] funct3_i,
    input  reg_t       rd_i,
    input  bus64_t     imm_i,
    output logic       ready_o,
    output bus64_t     data_o,
    output logic       lock_o,
    output logic       xcpt_ma_o,
    output logic       xcpt_pf_o,
    output bus64_t     io_data_o
);

    logic        dmem_req_valid;
    dcache_cmd_t dmem_req_cmd;
    addr_t       dmem_req_addr;
    logic [2:0]  dmem_op_type;
    bus64_t      dmem_req_data;
    logic [7:0]  dmem_req_tag;
    logic        dmem_req_invalidate_lr;
    logic        dmem_req_kill;
    logic        dmem_req_ready;
    logic        dmem_resp_valid;
    bus64_t      dmem_resp_data;
    logic        ma_ld;
    logic        ma_st;
    logic        pf_ld;
    logic        pf_st;

    mem_unit #(
        .IO_BASE  (IO_BASE),
        .IO_LIMIT (IO_LIMIT)
    ) i_mem_unit (
        .clk_i                    (clk_i),
        .rstn_i                   (rstn_i),
        .valid_i                  (valid_i),
        .kill_i                   (kill_i),
        .csr_eret_i               (csr_eret_i),
        .data_rs1_i               (data_rs1_i),
        .data_rs2_i               (data_rs2_i),
        .imm_i                    (imm_i),
        .mem_op_i                 (mem_op_i),
        .amo_op_i                 (amo_op_i),
        .funct3_i                 (funct3_i),
        .rd_i                     (rd_i),
        .dmem_req_ready_i         (dmem_req_ready),
        .dmem_resp_valid_i        (dmem_resp_valid),
        .dmem_resp_data_i         (dmem_resp_data),
        .dmem_xcpt_ma_ld_i        (ma_ld),
        .dmem_xcpt_ma_st_i        (ma_st),
        .dmem_xcpt_pf_ld_i        (pf_ld),
        .dmem_xcpt_pf_st_i        (pf_st),
        .dmem_req_valid_o         (dmem_req_valid),
        .dmem_req_cmd_o           (dmem_req_cmd),
        .dmem_req_addr_o          (dmem_req_addr),
        .dmem_op_type_o           (dmem_op_type),
        .dmem_req_data_o          (dmem_req_data),
        .dmem_req_tag_o           (dmem_req_tag),
        .dmem_req_invalidate_lr_o (dmem_req_invalidate_lr),
        .dmem_req_kill_o          (dmem_req_kill),
        .ready_o                  (ready_o),
        .data_o                   (data_o),
        .lock_o                   (lock_o)
    );

    data_scratchpad #(
        .MEM_WORDS    (MEM_WORDS),
        .RESP_LATENCY (RESP_LATENCY),
        .IO_BASE      (IO_BASE),
        .IO_LIMIT     (IO_LIMIT)
    ) i_data_scratchpad (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .req_valid_i         (dmem_req_valid),
        .req_cmd_i           (dmem_req_cmd),
        .req_addr_i          (dmem_req_addr),
        .op_type_i           (dmem_op_type),
        .req_data_i          (dmem_req_data),
        .req_tag_i           (dmem_req_tag),
        .req_invalidate_lr_i (dmem_req_invalidate_lr),
        .req_kill_i          (dmem_req_kill),
        .req_ready_o         (dmem_req_ready),
        .resp_valid_o        (dmem_resp_valid),
        .resp_data_o         (dmem_resp_data),
        .xcpt_ma_ld_o        (ma_ld),
        .xcpt_ma_st_o        (ma_st),
        .xcpt_pf_ld_o        (pf_ld),
        .xcpt_pf_st_o        (pf_st),
        .io_data_o           (io_data_o)
    );

    assign xcpt_ma_o = ma_ld | ma_st;
    assign xcpt_pf_o = pf_ld | pf_st;

endmodule

// File: bench/mem_subsystem_assert.sv
// handshake checks on the load/store unit, bound into every mem_unit
module mem_subsystem_assert (
    input logic clk_i,
    input logic rstn_i,
    input logic req_valid_i,
    input logic req_ready_i,
    input logic ready_i,
    input logic lock_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic req_seen_q;  // accepted request since the last ready pulse

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            req_seen_q <= 1'b0;
        end else if (req_valid_i && req_ready_i) begin
            req_seen_q <= 1'b1;
        end else if (ready_i) begin
            req_seen_q <= 1'b0;
        end
    end

    a_req_locked: assert property (@(posedge clk_i) disable iff (!rstn_i) req_valid_i |-> lock_i)
        else $error("request issued while lock_o is low");

    a_one_ready: assert property (@(posedge clk_i) disable iff (!rstn_i) ready_i |-> req_seen_q)
        else $error("ready_o pulsed twice without a request in between");

    a_lock_reset: assert property (@(posedge clk_i) $rose(rstn_i) |-> !lock_i)
        else $error("lock_o high right after reset release");

endmodule

bind mem_unit mem_subsystem_assert i_mem_subsystem_assert (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .req_valid_i (dmem_req_valid_o),
    .req_ready_i (dmem_req_ready_i),
    .ready_i     (ready_o),
    .lock_i      (lock_o)
);

// File: bench/mem_subsystem_tb.sv
// memory subsystem testbench, replays instruction vectors from a file and checks every response
module mem_subsystem_tb import mem_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int     CLK_HALF       = 5;
    localparam int     RESET_CYCLES   = 16;
    localparam int     RESP_LATENCY   = 2;
    localparam int     CYCLES_PER_VEC = 40;
    localparam int     MAX_WAIT       = 20;   // longest lock_o high per access
    localparam bus64_t IO_BASE        = 64'h1000;
    localparam bus64_t IO_LIMIT       = 64'h100F;
    localparam string  VEC_FILE       = "bench/mem_vectors.txt";

    typedef struct packed {
        logic [1:0]  op;
        logic [3:0]  amo;
        logic [2:0]  f3;
        logic [63:0] rs1;
        logic [63:0] rs2;
        logic [63:0] imm;
        logic        kill;
        logic        eret;
        logic [63:0] exp_data;  // load data, or io register after a store
        logic [1:0]  cls;       // 1 misaligned, 2 out of range
    } vector_t;

    logic       clk_i;
    logic       rstn_i;
    logic       valid_i;
    logic       kill_i;
    logic       csr_eret_i;
    bus64_t     data_rs1_i;
    bus64_t     data_rs2_i;
    bus64_t     imm_i;
    mem_op_t    mem_op_i;
    amo_op_t    amo_op_i;
    logic [2:0] funct3_i;
    reg_t       rd_i;
    logic       ready_o;
    bus64_t     data_o;
    logic       lock_o;
    logic       xcpt_ma_o;
    logic       xcpt_pf_o;
    bus64_t     io_data_o;

    vector_t vecs [$];
    int      limit_cycles = 0;

    mem_subsystem_top i_mem_subsystem_top (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .valid_i    (valid_i),
        .kill_i     (kill_i),
        .csr_eret_i (csr_eret_i),
        .data_rs1_i (data_rs1_i),
        .data_rs2_i (data_rs2_i),
        .mem_op_i   (mem_op_i),
        .amo_op_i   (amo_op_i),
        .funct3_i   (funct3_i),
        .rd_i       (rd_i),
        .imm_i      (imm_i),
        .ready_o    (ready_o),
        .data_o     (data_o),
        .lock_o     (lock_o),
        .xcpt_ma_o  (xcpt_ma_o),
        .xcpt_pf_o  (xcpt_pf_o),
        .io_data_o  (io_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #CLK_HALF clk_i = ~clk_i;
        end
    end

    // ------------------------------
    // reporting
    // ------------------------------
    task automatic abort_run(input string why);
        $display("*** FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input bus64_t got, input bus64_t expected);
        if (got !== expected) begin
            $display("** Error: %s got %h expected %h at %0t", name, got, expected, $time);
            abort_run("value mismatch");
        end
    endtask

    // comment lines start with #, every other line holds ten hex fields
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        vector_t     v;
        logic [63:0] t_op, t_amo, t_f3, t_rs1, t_rs2;
        logic [63:0] t_imm, t_kill, t_eret, t_exp, t_cls;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run("cannot open the vector file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", t_op, t_amo, t_f3,
                                t_rs1, t_rs2, t_imm, t_kill, t_eret, t_exp, t_cls);
                    if (n != 10) begin
                        abort_run("malformed line in the vector file");
                    end else begin
                        v.op       = t_op[1:0];
                        v.amo      = t_amo[3:0];
                        v.f3       = t_f3[2:0];
                        v.rs1      = t_rs1;
                        v.rs2      = t_rs2;
                        v.imm      = t_imm;
                        v.kill     = t_kill[0];
                        v.eret     = t_eret[0];
                        v.exp_data = t_exp;
                        v.cls      = t_cls[1:0];
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------
    // one instruction, held until lock_o falls
    // ------------------------------
    task automatic run_vector(input vector_t v, input int num);
        int         cyc;
        int         acc_cyc;
        int         rdy_cyc;
        int         rdy_cnt;
        int         low_cyc;
        int         exp_hold;
        logic [1:0] cls;
        bus64_t     got;
        logic       done;
        logic       is_store;
        logic       io_wr;
        cyc        = 0;
        acc_cyc    = -1;
        rdy_cyc    = -1;
        rdy_cnt    = 0;
        low_cyc    = -1;
        cls        = 2'b00;
        got        = '0;
        done       = 1'b0;
        is_store   = (mem_op_t'(v.op) == MEM_STORE);
        io_wr      = is_store && (v.rs1 + v.imm >= IO_BASE) && (v.rs1 + v.imm <= IO_LIMIT);
        valid_i    = 1'b1;
        kill_i     = v.kill;
        csr_eret_i = v.eret;
        mem_op_i   = mem_op_t'(v.op);
        amo_op_i   = amo_op_t'(v.amo);
        funct3_i   = v.f3;
        data_rs1_i = v.rs1;
        data_rs2_i = v.rs2;
        imm_i      = v.imm;
        rd_i       = reg_t'(num % 31 + 1);
        while (!done) begin
            @(negedge clk_i);
            if (cyc == 0) begin
                check_value("lock_o", {63'b0, lock_o}, {63'b0, ~v.kill});  // rises at once
            end
            if (i_mem_subsystem_top.dmem_req_valid && i_mem_subsystem_top.dmem_req_ready) begin
                acc_cyc = cyc;
            end
            if (ready_o) begin
                rdy_cnt++;
                rdy_cyc = cyc;
                got     = data_o;
            end
            cls = cls | {xcpt_pf_o, xcpt_ma_o};
            if (!lock_o) begin
                done    = 1'b1;
                low_cyc = cyc;
            end else if (cyc == MAX_WAIT) begin
                abort_run("lock_o stayed high past the wait limit");
            end
            cyc++;
        end
        check_value("xcpt_pf_o,xcpt_ma_o", {62'b0, cls}, {62'b0, v.cls});
        if (!v.kill) begin
            // excepting and io accesses get no response and unlock a cycle after acceptance
            exp_hold = (v.cls != 2'b00 || io_wr) ? 1 : RESP_LATENCY;
            check_value("lock_o fall cycle", 64'(low_cyc - acc_cyc), 64'(exp_hold));
        end
        if (v.kill || v.cls != 2'b00 || is_store) begin
            if (rdy_cnt != 0) begin
                abort_run("ready_o pulsed for a store, a killed or an excepting access");
            end else if (is_store) begin
                check_value("io_data_o", io_data_o, v.exp_data);
            end
        end else if (rdy_cnt != 1) begin
            abort_run("ready_o did not pulse exactly once for the access");
        end else begin
            check_value("ready_o latency", 64'(rdy_cyc - acc_cyc), 64'(RESP_LATENCY));
            check_value("data_o", got, v.exp_data);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        rstn_i     = 1'b0;
        valid_i    = 1'b0;
        kill_i     = 1'b0;
        csr_eret_i = 1'b0;
        data_rs1_i = '0;
        data_rs2_i = '0;
        imm_i      = '0;
        mem_op_i   = MEM_LOAD;
        amo_op_i   = AMO_LR;
        funct3_i   = SZ_D;
        rd_i       = '0;
        load_vectors();
        limit_cycles = vecs.size() * CYCLES_PER_VEC + RESET_CYCLES + 10;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
        @(posedge clk_i);
        #1;
        foreach (vecs[i]) begin
            run_vector(vecs[i], i);
            @(posedge clk_i);
            #1;
        end
        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_i);
        abort_run("watchdog expired before all vectors completed");
    end

endmodule

// File: bench/mem_vectors.txt
# op amo funct3 rs1 rs2 imm kill eret expected class, all hex; op 0 load 1 store 2 amo
# class 0 none 1 misaligned 2 out of range; for a store expected is the io register after it
1 0 3 f0 8877665544332211 10 0 0 0 0
1 0 0 100 ffffffffffffff81 9 0 0 0 0
1 0 1 100 1234f00d a 0 0 0 0
1 0 2 100 87654321 c 0 0 0 0
0 0 3 100 0 0 0 0 8877665544332211 0
0 0 0 100 0 7 0 0 ffffffffffffff88 0
0 0 4 100 0 7 0 0 88 0
0 0 1 100 0 6 0 0 ffffffffffff8877 0
0 0 5 100 0 2 0 0 4433 0
0 0 2 100 0 4 0 0 ffffffff88776655 0
0 0 6 100 0 4 0 0 88776655 0
0 0 3 100 0 8 0 0 87654321f00d8100 0
0 0 1 100 0 1 0 0 0 1
1 0 2 100 deadbeef 2 0 0 0 1
0 0 3 800 0 0 0 0 0 2
1 0 3 2000 5555 0 0 0 0 2
0 0 3 100 0 0 0 0 8877665544332211 0
2 2 3 200 8000000000000010 0 0 0 0 0
2 3 3 200 5 0 0 0 8000000000000010 0
2 4 3 200 ff 0 0 0 8000000000000015 0
2 5 3 200 f0000000000000f0 0 0 0 80000000000000ea 0
2 6 3 200 100000001 0 0 0 80000000000000e0 0
2 7 3 200 3 0 0 0 80000001000000e1 0
2 8 3 200 3 0 0 0 80000001000000e1 0
2 9 3 200 ffffffffffffffff 0 0 0 3 0
2 a 3 200 fffffffffffffff0 0 0 0 3 0
0 0 3 200 0 0 0 0 fffffffffffffff0 0
2 2 2 304 80000001 0 0 0 0 0
2 3 2 304 7ffffff0 0 0 0 ffffffff80000001 0
2 9 2 304 5 0 0 0 fffffffffffffff1 0
2 8 2 300 9 0 0 0 0 0
2 4 2 300 ffffffff 0 0 0 9 0
0 0 3 300 0 0 0 0 5fffffff6 0
2 0 3 400 0 0 0 0 0 0
2 1 3 400 1111 0 0 0 0 0
2 1 3 400 2222 0 0 0 1 0
2 0 3 400 0 0 0 0 1111 0
0 0 3 400 0 0 0 1 1111 0
2 1 3 400 3333 0 0 0 1 0
0 0 3 400 0 0 0 0 1111 0
1 0 3 1000 cafef00d12345678 8 0 0 cafef00d12345678 0
1 0 3 500 bad 0 1 0 cafef00d12345678 0
0 0 3 500 0 0 0 0 0 0

// File: vlog.f
design/mem_pkg.sv
design/amo_alu.sv
design/data_scratchpad.sv
design/mem_unit.sv
design/mem_subsystem_top.sv
bench/mem_subsystem_assert.sv
bench/mem_subsystem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the memory subsystem testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module mem_subsystem_tb \
    -f vlog.f \
    -o mem_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/mem_subsystem_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
fi
exit "$status"
